/* bench/exec_cluster_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_assert (
    input logic                     clock,
    input logic                     reset,
    input logic                     issue_valid,
    input exec_pkg::fu_sel_e        issue_unit,
    input logic                     addr_ready,
    input logic                     addr_stall,
    input logic                     addr_valid,
    input exec_pkg::complete_packet addr_result,
    input logic                     alu_valid,
    input exec_pkg::complete_packet alu_result,
    input exec_pkg::complete_packet cdb
);

    no_issue_while_busy: assert property (@(posedge clock) disable iff (reset)
        (issue_valid && issue_unit == exec_pkg::FU_ADDR) |-> addr_ready)
        else $error("address unit issued while addr_ready was low");

    held_result_stable: assert property (@(posedge clock) disable iff (reset)
        addr_stall |=> (addr_valid && $stable(addr_result)))
        else $error("stalled address result changed or was dropped");

    alu_owns_bus: assert property (@(posedge clock) disable iff (reset)
        alu_valid |-> (cdb == alu_result))
        else $error("integer result missing from the bus while valid");

endmodule

bind exec_cluster exec_cluster_assert u_exec_cluster_assert (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_unit  (issue_unit),
    .addr_ready  (addr_ready),
    .addr_stall  (addr_stall),
    .addr_valid  (addr_valid),
    .addr_result (addr_result),
    .alu_valid   (alu_valid),
    .alu_result  (alu_result),
    .cdb         (cdb)
);

`default_nettype wire

/* bench/exec_cluster_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32_imm.svh"

module exec_cluster_tb;

    localparam int alu_issues     = 200;
    localparam int addr_issues    = 200;
    localparam int mixed_issues   = 400;
    localparam int pair_rounds    = 10;
    localparam int total_issues   = alu_issues + addr_issues + 4 * pair_rounds + mixed_issues;
    localparam int timeout_cycles = total_issues * 4 + 100;

    typedef struct packed {
        exec_pkg::complete_packet pkt;
        logic [31:0]              cycle;   // Cycle of the issue edge.
        logic [2:0]               test_id;
    } expect_entry;

    logic                     clock;
    logic                     reset;
    logic                     issue_valid;
    exec_pkg::fu_sel_e        issue_unit;
    exec_pkg::issue_packet    issue;
    logic                     alu_ready;
    logic                     addr_ready;
    logic                     cdb_valid;
    exec_pkg::complete_packet cdb;

    expect_entry alu_queue[$];
    expect_entry addr_queue[$];
    int          tags_issued [32];
    int          tags_seen [32];
    int          cycle_count;
    int          issue_count;
    int          addr_stalls;
    int          value_errors;
    int          other_errors;
    logic [31:0] rng_state;

    exec_cluster u_exec_cluster (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_unit  (issue_unit),
        .issue       (issue),
        .alu_ready   (alu_ready),
        .addr_ready  (addr_ready),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd1:    return "reset";
            3'd2:    return "alu_random";
            3'd3:    return "addr_random";
            3'd4:    return "bus_contention";
            default: return "mixed_random";
        endcase
    endfunction

    function automatic exec_pkg::complete_packet expected_result(
        input exec_pkg::issue_packet p,
        input exec_pkg::fu_sel_e     unit
    );
        logic [31:0]              a;
        logic [31:0]              b;
        logic [63:0]              wide;
        exec_pkg::complete_packet c;
        case (p.opa_select)
            exec_pkg::OPA_IS_RS1:  a = p.rs1_value;
            exec_pkg::OPA_IS_NPC:  a = p.npc;
            exec_pkg::OPA_IS_PC:   a = p.pc;
            exec_pkg::OPA_IS_ZERO: a = 32'h0;
            default:               a = 32'hdeadface;
        endcase
        case (p.opb_select)
            exec_pkg::OPB_IS_RS2:   b = p.rs2_value;
            exec_pkg::OPB_IS_I_IMM: b = `rv32_signext_i_imm(p.inst);
            exec_pkg::OPB_IS_S_IMM: b = `rv32_signext_s_imm(p.inst);
            exec_pkg::OPB_IS_B_IMM: b = `rv32_signext_b_imm(p.inst);
            exec_pkg::OPB_IS_U_IMM: b = `rv32_signext_u_imm(p.inst);
            exec_pkg::OPB_IS_J_IMM: b = `rv32_signext_j_imm(p.inst);
            default:                b = 32'hfacefeed;
        endcase
        c     = '0;
        c.tag = p.tag;
        if (unit == exec_pkg::FU_ADDR) begin
            c.result     = a + b;
            c.store_data = p.rs2_value;
            c.mem_size   = p.mem_size;
            c.is_mem     = 1'b1;
            c.is_store   = p.is_store;
        end else begin
            wide = {{32{a[31]}}, a} >> b[4:0];     // Arithmetic shift via sign fill.
            case (p.alu_op)
                exec_pkg::ALU_ADD:  c.result = a + b;
                exec_pkg::ALU_SUB:  c.result = a + ~b + 32'd1;
                exec_pkg::ALU_AND:  c.result = a & b;
                exec_pkg::ALU_OR:   c.result = a | b;
                exec_pkg::ALU_XOR:  c.result = a ^ b;
                exec_pkg::ALU_SLT:  c.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                exec_pkg::ALU_SLTU: c.result = (a < b) ? 32'd1 : 32'd0;
                exec_pkg::ALU_SLL:  c.result = a << b[4:0];
                exec_pkg::ALU_SRL:  c.result = a >> b[4:0];
                exec_pkg::ALU_SRA:  c.result = wide[31:0];
                default:            c.result = 32'h0;
            endcase
        end
        return c;
    endfunction

    function automatic exec_pkg::issue_packet random_issue(
        input exec_pkg::fu_sel_e unit,
        input logic [3:0]        op
    );
        exec_pkg::issue_packet p;
        logic [31:0]           pick;
        p           = '0;
        p.inst      = next_random();
        p.rs1_value = next_random();
        p.rs2_value = next_random();
        p.pc        = next_random() & 32'hffff_fffc;
        p.npc       = p.pc + 32'd4;
        pick        = next_random();
        if (unit == exec_pkg::FU_ALU) begin
            case (pick % 3)
                0:       p.opa_select = exec_pkg::OPA_IS_RS1;
                1:       p.opa_select = exec_pkg::OPA_IS_PC;
                default: p.opa_select = exec_pkg::OPA_IS_ZERO;
            endcase
            case ((pick >> 4) % 3)
                0:       p.opb_select = exec_pkg::OPB_IS_RS2;
                1:       p.opb_select = exec_pkg::OPB_IS_I_IMM;
                default: p.opb_select = exec_pkg::OPB_IS_U_IMM;
            endcase
            p.alu_op = exec_pkg::alu_op_e'(op);
        end else begin
            p.opa_select = exec_pkg::OPA_IS_RS1;
            p.opb_select = pick[0] ? exec_pkg::OPB_IS_S_IMM : exec_pkg::OPB_IS_I_IMM;
            p.alu_op     = exec_pkg::ALU_ADD;
            p.is_store   = pick[5];
            p.mem_size   = exec_pkg::mem_size_e'(2'((pick >> 8) % 3));
        end
        return p;
    endfunction

    // Called on a falling edge, returns on the next one.
    task automatic send(
        input exec_pkg::fu_sel_e     unit,
        input exec_pkg::issue_packet p,
        input logic [2:0]            test_id
    );
        expect_entry e;
        while (unit == exec_pkg::FU_ADDR && !addr_ready) begin
            issue_valid = 1'b0;
            @(negedge clock);
        end
        p.tag       = issue_count[4:0];
        issue_valid = 1'b1;
        issue_unit  = unit;
        issue       = p;
        e.pkt       = expected_result(p, unit);
        e.cycle     = cycle_count;
        e.test_id   = test_id;
        if (unit == exec_pkg::FU_ALU) begin
            alu_queue.push_back(e);
        end else begin
            addr_queue.push_back(e);
        end
        tags_issued[p.tag]++;
        issue_count++;
        @(negedge clock);
        issue_valid = 1'b0;
    endtask

    task automatic check_completion(input expect_entry e, input int stalls);
        int latency;
        latency = cycle_count - int'(e.cycle);
        assert (cdb == e.pkt) else begin
            $display("error %s: expected %h, actual %h", test_label(e.test_id), e.pkt, cdb);
            value_errors++;
        end
        assert (latency == 1 + stalls) else begin
            $display("error %s latency: expected %0d, actual %0d",
                     test_label(e.test_id), 1 + stalls, latency);
            value_errors++;
        end
        tags_seen[cdb.tag]++;
    endtask

    // Outputs are read before this edge updates them.
    always @(posedge clock) begin : compare_cdb
        expect_entry e;
        expect_entry front;
        logic        alu_busy;
        logic        addr_busy;
        logic        expect_ready;
        if (!reset) begin
            alu_busy  = 1'b0;
            addr_busy = 1'b0;
            if (alu_queue.size() > 0) begin
                front    = alu_queue[0];
                alu_busy = int'(front.cycle) < cycle_count;
            end
            if (addr_queue.size() > 0) begin
                front     = addr_queue[0];
                addr_busy = int'(front.cycle) < cycle_count;
            end
            expect_ready = !(alu_busy && addr_busy);
            if (alu_busy && addr_busy) begin
                addr_stalls++;                     // Address result waits for the bus.
            end
            if (cdb_valid && cdb.is_mem) begin
                assert (addr_queue.size() > 0) else begin
                    $display("address result tag %0d on the bus with none pending", cdb.tag);
                    other_errors++;
                end
                if (addr_queue.size() > 0) begin
                    e = addr_queue.pop_front();
                    check_completion(e, addr_stalls);
                    addr_stalls = 0;
                end
            end else if (cdb_valid) begin
                assert (alu_queue.size() > 0) else begin
                    $display("integer result tag %0d on the bus with none pending", cdb.tag);
                    other_errors++;
                end
                if (alu_queue.size() > 0) begin
                    e = alu_queue.pop_front();
                    check_completion(e, 0);
                end
            end
            assert (alu_ready) else begin
                $display("alu_ready dropped although the integer unit never stalls");
                other_errors++;
            end
            assert (addr_ready == expect_ready) else begin
                $display("error addr_ready: expected %b, actual %b", expect_ready, addr_ready);
                value_errors++;
            end
            assert (cdb_valid || cdb == '0) else begin
                $display("error idle_bus: expected %h, actual %h", 73'h0, cdb);
                value_errors++;
            end
        end
        cycle_count++;
    end

    initial begin : watchdog
        int waited;
        waited = 0;
        while (waited < timeout_cycles) begin
            @(posedge clock);
            waited++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] pick;
        reset        = 1'b1;
        issue_valid  = 1'b0;
        issue_unit   = exec_pkg::FU_ALU;
        issue        = '0;
        rng_state    = 32'hdc95_9b59;
        cycle_count  = 0;
        issue_count  = 0;
        addr_stalls  = 0;
        value_errors = 0;
        other_errors = 0;
        for (int t = 0; t < 32; t++) begin
            tags_issued[t] = 0;
            tags_seen[t]   = 0;
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        assert (!cdb_valid && alu_ready && addr_ready) else begin
            $display("error reset: expected 011, actual %b%b%b", cdb_valid, alu_ready, addr_ready);
            value_errors++;
        end

        for (int i = 0; i < alu_issues; i++) begin
            send(exec_pkg::FU_ALU, random_issue(exec_pkg::FU_ALU, 4'(i % 10)), 3'd2);
        end

        while (alu_queue.size() != 0) @(negedge clock);
        for (int i = 0; i < addr_issues; i++) begin
            send(exec_pkg::FU_ADDR, random_issue(exec_pkg::FU_ADDR, 4'd0), 3'd3);
        end
        while (addr_queue.size() != 0) @(negedge clock);

        for (int r = 0; r < pair_rounds; r++) begin
            send(exec_pkg::FU_ADDR, random_issue(exec_pkg::FU_ADDR, 4'd0), 3'd4);
            send(exec_pkg::FU_ALU, random_issue(exec_pkg::FU_ALU, 4'(r % 10)), 3'd4);
            send(exec_pkg::FU_ADDR, random_issue(exec_pkg::FU_ADDR, 4'd0), 3'd4);
            send(exec_pkg::FU_ALU, random_issue(exec_pkg::FU_ALU, 4'((r + 5) % 10)), 3'd4);
        end

        for (int i = 0; i < mixed_issues; i++) begin
            pick = next_random();
            if (pick[0]) begin
                send(exec_pkg::FU_ADDR, random_issue(exec_pkg::FU_ADDR, 4'd0), 3'd5);
            end else begin
                send(exec_pkg::FU_ALU, random_issue(exec_pkg::FU_ALU, 4'(pick[11:8] % 10)), 3'd5);
            end
            if (pick[3:2] == 2'b00) begin
                @(negedge clock);                  // Idle gap.
            end
        end

        while (alu_queue.size() != 0 || addr_queue.size() != 0) @(negedge clock);
        repeat (3) @(negedge clock);
        assert (!cdb_valid) else begin
            $display("cdb_valid is still high after all results completed");
            other_errors++;
        end
        for (int t = 0; t < 32; t++) begin
            assert (tags_seen[t] == tags_issued[t]) else begin
                $display("error tag_count %0d: expected %0d, actual %0d",
                         t, tags_issued[t], tags_seen[t]);
                value_errors++;
            end
        end

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/addr_calc.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_calc (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     start,
    input  exec_pkg::issue_packet    issue,
    input  logic                     stall,
    output logic                     ready,
    output logic                     out_valid,
    output exec_pkg::complete_packet result
);

    logic [31:0]              opa;
    logic [31:0]              opb;
    exec_pkg::complete_packet next_result;

    operand_select u_operand_select (
        .issue (issue),
        .opa   (opa),
        .opb   (opb)
    );

    always_comb begin
        next_result.tag        = issue.tag;
        next_result.result     = opa + opb;        // Base plus offset.
        next_result.store_data = issue.rs2_value;
        next_result.mem_size   = issue.mem_size;
        next_result.is_mem     = 1'b1;
        next_result.is_store   = issue.is_store;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result    <= '0;
            out_valid <= 1'b0;
        end else if (stall) begin
            result    <= result;               // Lost the bus, keep it.
            out_valid <= out_valid;
        end else if (start) begin
            result    <= next_result;
            out_valid <= 1'b1;
        end else begin
            result    <= '0;
            out_valid <= 1'b0;
        end
    end

    assign ready = !(out_valid && stall);

endmodule

`default_nettype wire

/* hdl/complete_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module complete_arbiter (
    input  logic                     alu_valid,
    input  exec_pkg::complete_packet alu_result,
    input  logic                     addr_valid,
    input  exec_pkg::complete_packet addr_result,
    output logic                     cdb_valid,
    output exec_pkg::complete_packet cdb,
    output logic                     addr_stall
);

    logic alu_grant;
    logic addr_grant;

    // Integer unit always wins.
    assign alu_grant  = alu_valid;
    assign addr_grant = addr_valid && !alu_valid;

    assign addr_stall = addr_valid && !addr_grant;
    assign cdb_valid  = alu_valid || addr_valid;

    always_comb begin
        if (alu_grant) begin
            cdb = alu_result;
        end else if (addr_grant) begin
            cdb = addr_result;
        end else begin
            cdb = '0;                          // Idle bus.
        end
    end

endmodule

`default_nettype wire

/* hdl/exec_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     issue_valid,
    input  exec_pkg::fu_sel_e        issue_unit,
    input  exec_pkg::issue_packet    issue,
    output logic                     alu_ready,
    output logic                     addr_ready,
    output logic                     cdb_valid,
    output exec_pkg::complete_packet cdb
);

    logic                     alu_start;
    logic                     addr_start;
    logic                     alu_valid;
    logic                     addr_valid;
    logic                     addr_stall;
    exec_pkg::complete_packet alu_result;
    exec_pkg::complete_packet addr_result;

    assign alu_ready  = 1'b1;
    assign alu_start  = issue_valid && alu_ready && (issue_unit == exec_pkg::FU_ALU);
    assign addr_start = issue_valid && addr_ready && (issue_unit == exec_pkg::FU_ADDR);

    int_alu_unit u_int_alu_unit (
        .clock     (clock),
        .reset     (reset),
        .start     (alu_start),
        .issue     (issue),
        .out_valid (alu_valid),
        .result    (alu_result)
    );

    addr_calc u_addr_calc (
        .clock     (clock),
        .reset     (reset),
        .start     (addr_start),
        .issue     (issue),
        .stall     (addr_stall),
        .ready     (addr_ready),
        .out_valid (addr_valid),
        .result    (addr_result)
    );

    complete_arbiter u_complete_arbiter (
        .alu_valid   (alu_valid),
        .alu_result  (alu_result),
        .addr_valid  (addr_valid),
        .addr_result (addr_result),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb),
        .addr_stall  (addr_stall)
    );

endmodule

`default_nettype wire

/* hdl/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    localparam int xlen      = 32;
    localparam int tag_width = 5;

    // Significant bits of each immediate form before extension.
    localparam int i_imm_width = 12;
    localparam int s_imm_width = 12;
    localparam int b_imm_width = 13;
    localparam int u_imm_width = 20;
    localparam int j_imm_width = 21;

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_NPC  = 2'h1,
        OPA_IS_PC   = 2'h2,
        OPA_IS_ZERO = 2'h3
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'h0,
        OPB_IS_I_IMM = 3'h1,
        OPB_IS_S_IMM = 3'h2,
        OPB_IS_B_IMM = 3'h3,
        OPB_IS_U_IMM = 3'h4,
        OPB_IS_J_IMM = 3'h5
    } opb_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_SLT  = 4'h5,
        ALU_SLTU = 4'h6,
        ALU_SLL  = 4'h7,
        ALU_SRL  = 4'h8,
        ALU_SRA  = 4'h9
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'h0,
        MEM_HALF = 2'h1,
        MEM_WORD = 2'h2
    } mem_size_e;

    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_ADDR = 1'b1
    } fu_sel_e;

    typedef struct packed {
        logic [31:0]          inst;
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      npc;
        logic [xlen-1:0]      rs1_value;
        logic [xlen-1:0]      rs2_value;
        opa_sel_e             opa_select;
        opb_sel_e             opb_select;
        alu_op_e              alu_op;
        mem_size_e            mem_size;
        logic                 is_store;
        logic [tag_width-1:0] tag;
    } issue_packet;

    typedef struct packed {
        logic [tag_width-1:0] tag;
        logic [xlen-1:0]      result;      // ALU value or effective address.
        logic [xlen-1:0]      store_data;
        mem_size_e            mem_size;
        logic                 is_mem;
        logic                 is_store;
    } complete_packet;

endpackage

`default_nettype wire

/* hdl/int_alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module int_alu_unit (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     start,
    input  exec_pkg::issue_packet    issue,
    output logic                     out_valid,
    output exec_pkg::complete_packet result
);

    logic [31:0]              opa;
    logic [31:0]              opb;
    logic [31:0]              alu_value;
    exec_pkg::complete_packet next_result;

    operand_select u_operand_select (
        .issue (issue),
        .opa   (opa),
        .opb   (opb)
    );

    always_comb begin
        case (issue.alu_op)
            exec_pkg::ALU_ADD:  alu_value = opa + opb;
            exec_pkg::ALU_SUB:  alu_value = opa - opb;
            exec_pkg::ALU_AND:  alu_value = opa & opb;
            exec_pkg::ALU_OR:   alu_value = opa | opb;
            exec_pkg::ALU_XOR:  alu_value = opa ^ opb;
            exec_pkg::ALU_SLT:  alu_value = {31'b0, $signed(opa) < $signed(opb)};
            exec_pkg::ALU_SLTU: alu_value = {31'b0, opa < opb};
            exec_pkg::ALU_SLL:  alu_value = opa << opb[4:0];
            exec_pkg::ALU_SRL:  alu_value = opa >> opb[4:0];
            exec_pkg::ALU_SRA:  alu_value = $signed(opa) >>> opb[4:0];
            default:            alu_value = '0;
        endcase
    end

    // Register results carry no memory information.
    always_comb begin
        next_result        = '0;
        next_result.tag    = issue.tag;
        next_result.result = alu_value;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= start;                // Always granted, never held.
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            result <= next_result;
        end
    end

endmodule

`default_nettype wire

/* hdl/operand_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv32_imm.svh"

module operand_select (
    input  exec_pkg::issue_packet issue,
    output logic [31:0]           opa,
    output logic [31:0]           opb
);

    always_comb begin
        case (issue.opa_select)
            exec_pkg::OPA_IS_RS1:  opa = issue.rs1_value;
            exec_pkg::OPA_IS_NPC:  opa = issue.npc;
            exec_pkg::OPA_IS_PC:   opa = issue.pc;
            exec_pkg::OPA_IS_ZERO: opa = '0;
            default:               opa = 32'hdeadface; // Fill marker.
        endcase
    end

    always_comb begin
        case (issue.opb_select)
            exec_pkg::OPB_IS_RS2:   opb = issue.rs2_value;
            exec_pkg::OPB_IS_I_IMM: opb = `rv32_signext_i_imm(issue.inst);
            exec_pkg::OPB_IS_S_IMM: opb = `rv32_signext_s_imm(issue.inst);
            exec_pkg::OPB_IS_B_IMM: opb = `rv32_signext_b_imm(issue.inst);
            exec_pkg::OPB_IS_U_IMM: opb = `rv32_signext_u_imm(issue.inst);
            exec_pkg::OPB_IS_J_IMM: opb = `rv32_signext_j_imm(issue.inst);
            default:                opb = 32'hfacefeed; // Fill marker.
        endcase
    end

endmodule

`default_nettype wire

/* hdl/rv32_imm.svh */
`ifndef RV32_IMM_SVH
`define RV32_IMM_SVH

// Immediate extraction for the RV32I instruction formats.

`define rv32_signext_i_imm(inst) \
    {{(exec_pkg::xlen - exec_pkg::i_imm_width){inst[31]}}, inst[31:20]}

`define rv32_signext_s_imm(inst) \
    {{(exec_pkg::xlen - exec_pkg::s_imm_width){inst[31]}}, inst[31:25], inst[11:7]}

`define rv32_signext_b_imm(inst) \
    {{(exec_pkg::xlen - exec_pkg::b_imm_width){inst[31]}}, inst[31], inst[7], \
     inst[30:25], inst[11:8], 1'b0}

`define rv32_signext_u_imm(inst) \
    {inst[31:12], {(exec_pkg::xlen - exec_pkg::u_imm_width){1'b0}}}

`define rv32_signext_j_imm(inst) \
    {{(exec_pkg::xlen - exec_pkg::j_imm_width){inst[31]}}, inst[31], inst[19:12], \
     inst[20], inst[30:21], 1'b0}

`endif

/* vlog.f */
+incdir+hdl
hdl/exec_pkg.sv
hdl/operand_select.sv
hdl/addr_calc.sv
hdl/int_alu_unit.sv
hdl/complete_arbiter.sv
hdl/exec_cluster.sv
bench/exec_cluster_assert.sv
bench/exec_cluster_tb.sv
